// File: vlog.f
source/MemMapTypes.sv
source/MemPipeTypes.sv
source/SelectiveFlushDetector.sv
source/MemoryAddressUnit.sv
source/CsrUnit.sv
source/MemoryExecutionStage.sv
source/MemoryExecutionTop.sv
verification/ClockGenerator.sv
verification/MemoryExecutionTb.sv

// File: verification/MemoryExecutionTb.sv
/*
  Random testbench for the memory execution stage and its CSR unit.
  Lane 0 draws loads, CSR ops and fences; lane 1 draws stores only.
  Every output field is compared each cycle, whether the lane is valid or not.
*/
`timescale 1ns/1ps
`default_nettype none

module MemoryExecutionTb;

    localparam realtime CLK_PERIOD = 4.0;
    localparam int RESET_CYCLES = 2;
    localparam int NUM_CYCLES = 3000;
    localparam int MARGIN_CYCLES = 50;
    localparam realtime DRIVE_DELAY = 1.0;
    localparam realtime SAMPLE_DELAY = 3.0;
    localparam realtime TIMEOUT = (NUM_CYCLES + RESET_CYCLES + MARGIN_CYCLES) * CLK_PERIOD;

    typedef struct packed {
        MemPipeTypes::TagAccessRecord storeLane;
        MemPipeTypes::TagAccessRecord loadLane;
        MemPipeTypes::DcReadRequest dcRead;
        logic cacheFlushReq;
    } Expectation;

    logic clk;
    logic reset;
    MemPipeTypes::MemExecRecord prevStage [MemPipeTypes::MEM_ISSUE_WIDTH];
    MemPipeTypes::OperandData bypassA [MemPipeTypes::MEM_ISSUE_WIDTH];
    MemPipeTypes::OperandData bypassB [MemPipeTypes::MEM_ISSUE_WIDTH];
    logic stall;
    logic clear;
    MemPipeTypes::RecoveryInfo recovery;
    logic cacheFlushComplete;
    MemPipeTypes::TagAccessRecord nextStage [MemPipeTypes::MEM_ISSUE_WIDTH];
    MemPipeTypes::DcReadRequest dcRead;
    logic cacheFlushReq;

    // Model of the stage register and the CSR file
    MemPipeTypes::MemExecRecord heldRecord [MemPipeTypes::MEM_ISSUE_WIDTH];
    MemPipeTypes::DataPath csrMirror [MemPipeTypes::CSR_SCRATCH_COUNT];
    Expectation expectQueue [$];
    int checkCount;

    ClockGenerator #(
        .PERIOD(CLK_PERIOD),
        .RESET_CYCLES(RESET_CYCLES)
    ) clockGen (
        .clk(clk),
        .reset(reset)
    );

    MemoryExecutionTop dut (
        .clk(clk),
        .reset(reset),
        .prevStage(prevStage),
        .bypassA(bypassA),
        .bypassB(bypassB),
        .stall(stall),
        .clear(clear),
        .recovery(recovery),
        .cacheFlushComplete(cacheFlushComplete),
        .nextStage(nextStage),
        .dcRead(dcRead),
        .cacheFlushReq(cacheFlushReq)
    );

    // Bases land in memory, I/O or anywhere
    function automatic MemPipeTypes::DataPath randomBase();
        MemPipeTypes::DataPath base;
        case ($urandom_range(2))
            0: base = {MemMapTypes::MEMORY_REGION_TAG, 28'($urandom)};
            1: base = {MemMapTypes::IO_REGION_TAG, 28'($urandom)};
            default: base = $urandom;
        endcase
        return base;
    endfunction

    function automatic MemPipeTypes::OperandData randomOperand();
        MemPipeTypes::OperandData op;
        op.valid = $urandom_range(99) < 85;
        op.data = randomBase();
        return op;
    endfunction

    function automatic MemPipeTypes::MemExecRecord randomRecord(input int lane);
        MemPipeTypes::MemExecRecord rec;
        int pick;
        rec = '0;
        rec.valid = $urandom_range(99) < 80;
        rec.activeListPtr = MemPipeTypes::ActiveListPtr'($urandom_range(31));
        pick = $urandom_range(9);
        if (lane == MemPipeTypes::STORE_LANE) begin
            rec.memOpInfo.opType = MemPipeTypes::MEM_OP_STORE;
        end else if (pick < 5) begin
            rec.memOpInfo.opType = MemPipeTypes::MEM_OP_LOAD;
        end else if (pick < 8) begin
            rec.memOpInfo.opType = MemPipeTypes::MEM_OP_CSR;
        end else begin
            rec.memOpInfo.opType = MemPipeTypes::MEM_OP_FENCE;
        end
        rec.memOpInfo.operandTypeA = ($urandom_range(3) == 0) ?
            MemPipeTypes::OPERAND_IMM : MemPipeTypes::OPERAND_REG;
        rec.memOpInfo.operandTypeB = ($urandom_range(3) == 0) ?
            MemPipeTypes::OPERAND_IMM : MemPipeTypes::OPERAND_REG;
        // CSR ops mostly hit the scratch block
        if (rec.memOpInfo.opType == MemPipeTypes::MEM_OP_CSR && $urandom_range(9) < 8) begin
            rec.memOpInfo.addrIn = MemPipeTypes::CSR_SCRATCH_BASE + 12'($urandom_range(3));
        end else begin
            rec.memOpInfo.addrIn = 12'($urandom);
        end
        rec.memOpInfo.isFenceI = rec.memOpInfo.opType == MemPipeTypes::MEM_OP_FENCE &&
                                 $urandom_range(3) != 0;
        rec.memOpInfo.csrCode = MemPipeTypes::CsrCode'($urandom_range(2));
        rec.memOpInfo.csrIsImm = $urandom_range(1);
        rec.memOpInfo.csrImm = 5'($urandom);
        rec.bypassA = $urandom_range(99) < 30;
        rec.bypassB = $urandom_range(99) < 30;
        rec.operandA = randomOperand();
        rec.operandB = randomOperand();
        return rec;
    endfunction

    // Records for the next capture, side inputs for this cycle
    task automatic driveInputs();
        for (int i = 0; i < MemPipeTypes::MEM_ISSUE_WIDTH; i++) begin
            prevStage[i] = randomRecord(i);
            bypassA[i] = randomOperand();
            bypassB[i] = randomOperand();
        end
        stall = $urandom_range(99) < 15;
        clear = $urandom_range(99) < 8;
        recovery.toRecoveryPhase = $urandom_range(99) < 25;
        recovery.flushAll = $urandom_range(99) < 20;
        recovery.flushHeadPtr = MemPipeTypes::ActiveListPtr'($urandom_range(31));
        recovery.flushTailPtr = MemPipeTypes::ActiveListPtr'($urandom_range(31));
        cacheFlushComplete = $urandom_range(99) < 35;
    endtask

    // Distance from head on the ring, so a wrapped range needs no special case
    function automatic logic flushCovers(input MemPipeTypes::RecoveryInfo rec,
                                         input MemPipeTypes::ActiveListPtr ptr);
        MemPipeTypes::ActiveListPtr offset;
        MemPipeTypes::ActiveListPtr span;
        offset = ptr - rec.flushHeadPtr;
        span = rec.flushTailPtr - rec.flushHeadPtr;
        return rec.toRecoveryPhase && (rec.flushAll || offset < span);
    endfunction

    function automatic logic csrMapped(input logic [MemPipeTypes::CSR_NUMBER_WIDTH-1:0] number);
        return (number & ~12'h3) == MemPipeTypes::CSR_SCRATCH_BASE;
    endfunction

    function automatic MemPipeTypes::DataPath csrRead(
        input logic [MemPipeTypes::CSR_NUMBER_WIDTH-1:0] number
    );
        MemPipeTypes::DataPath value;
        if (csrMapped(number)) begin
            value = csrMirror[number[1:0]];
        end else begin
            value = '0;
        end
        return value;
    endfunction

    function automatic logic fenceIHeld();
        MemPipeTypes::MemExecRecord rec;
        rec = heldRecord[MemPipeTypes::LOAD_LANE];
        return rec.valid && rec.memOpInfo.opType == MemPipeTypes::MEM_OP_FENCE &&
               rec.memOpInfo.isFenceI;
    endfunction

    function automatic MemPipeTypes::TagAccessRecord expectLane(input int lane);
        MemPipeTypes::MemExecRecord rec;
        MemPipeTypes::OperandData opA;
        MemPipeTypes::OperandData opB;
        MemPipeTypes::TagAccessRecord exp;
        int signedImm;
        logic isIo;
        rec = heldRecord[lane];
        opA = rec.bypassA ? bypassA[lane] : rec.operandA;
        opB = rec.bypassB ? bypassB[lane] : rec.operandB;
        exp.valid = rec.valid && !stall && !clear && !flushCovers(recovery, rec.activeListPtr);
        exp.activeListPtr = rec.activeListPtr;
        exp.opType = rec.memOpInfo.opType;
        exp.regValid = (rec.memOpInfo.operandTypeA == MemPipeTypes::OPERAND_IMM || opA.valid) &&
                       (rec.memOpInfo.operandTypeB == MemPipeTypes::OPERAND_IMM || opB.valid);
        if (lane == MemPipeTypes::LOAD_LANE && fenceIHeld() && !cacheFlushComplete) begin
            exp.regValid = 1'b0;
        end
        if (lane == MemPipeTypes::LOAD_LANE && rec.memOpInfo.opType == MemPipeTypes::MEM_OP_CSR) begin
            exp.dataIn = csrRead(rec.memOpInfo.addrIn);
        end else begin
            exp.dataIn = opB.data;
        end
        signedImm = $signed(rec.memOpInfo.addrIn);
        exp.addrOut = opA.data + MemPipeTypes::DataPath'(signedImm);
        case (exp.addrOut[MemPipeTypes::DATA_WIDTH-1 -: MemMapTypes::REGION_TAG_WIDTH])
            MemMapTypes::MEMORY_REGION_TAG: exp.memMapType = MemMapTypes::MMT_MEMORY;
            MemMapTypes::IO_REGION_TAG: exp.memMapType = MemMapTypes::MMT_IO;
            default: exp.memMapType = MemMapTypes::MMT_ILLEGAL;
        endcase
        isIo = exp.memMapType == MemMapTypes::MMT_IO;
        exp.phyAddrOut = {isIo, exp.addrOut[MemMapTypes::PHY_OFFSET_WIDTH-1:0]};
        return exp;
    endfunction

    function automatic Expectation referenceModel();
        Expectation exp;
        exp.loadLane = expectLane(MemPipeTypes::LOAD_LANE);
        exp.storeLane = expectLane(MemPipeTypes::STORE_LANE);
        exp.cacheFlushReq = fenceIHeld();
        // A surviving output valid already excludes stall, clear and flush
        exp.dcRead.req = exp.loadLane.valid && exp.loadLane.regValid &&
                         exp.loadLane.opType == MemPipeTypes::MEM_OP_LOAD;
        exp.dcRead.phyAddr = exp.loadLane.phyAddrOut;
        exp.dcRead.uncachable = exp.loadLane.phyAddrOut[MemMapTypes::PHY_ADDR_WIDTH-1];
        exp.dcRead.activeListPtr = heldRecord[MemPipeTypes::LOAD_LANE].activeListPtr;
        return exp;
    endfunction

    // CSR write of the cycle that just ended, stall or not
    task automatic commitCsrWrite();
        MemPipeTypes::MemExecRecord rec;
        MemPipeTypes::DataPath source;
        MemPipeTypes::DataPath oldValue;
        logic [MemPipeTypes::CSR_INDEX_WIDTH-1:0] index;
        rec = heldRecord[MemPipeTypes::LOAD_LANE];
        if (rec.valid && rec.memOpInfo.opType == MemPipeTypes::MEM_OP_CSR &&
            csrMapped(rec.memOpInfo.addrIn)) begin
            if (rec.memOpInfo.csrIsImm) begin
                source = MemPipeTypes::DataPath'(rec.memOpInfo.csrImm);
            end else if (rec.bypassA) begin
                source = bypassA[MemPipeTypes::LOAD_LANE].data;
            end else begin
                source = rec.operandA.data;
            end
            oldValue = csrRead(rec.memOpInfo.addrIn);
            index = rec.memOpInfo.addrIn[1:0];
            case (rec.memOpInfo.csrCode)
                MemPipeTypes::CSR_WRITE: csrMirror[index] = source;
                MemPipeTypes::CSR_SET: csrMirror[index] = oldValue | source;
                default: csrMirror[index] = oldValue & ~source;
            endcase
        end
    endtask

    task automatic failRun();
        $display("Test FAILED");
        $fatal(1, "Run stopped at the first mismatch");
    endtask

    task automatic showRecord(input string tag, input MemPipeTypes::TagAccessRecord r);
        $display("  %s valid=%b ptr=%0d op=%s regValid=%b data=%h addr=%h phy=%h map=%s",
                 tag, r.valid, r.activeListPtr, r.opType.name(), r.regValid, r.dataIn,
                 r.addrOut, r.phyAddrOut, r.memMapType.name());
    endtask

    task automatic checkTagAccess(input int lane, input MemPipeTypes::TagAccessRecord got,
                                  input MemPipeTypes::TagAccessRecord exp);
        if (got !== exp) begin
            $display("[ERROR] %0t: tag access record of lane %0d differs", $time, lane);
            showRecord("got     ", got);
            showRecord("expected", exp);
            failRun();
        end
    endtask

    task automatic checkDcRead(input MemPipeTypes::DcReadRequest got,
                               input MemPipeTypes::DcReadRequest exp);
        if (got !== exp) begin
            $display("[ERROR] %0t: dcache read request differs, got req=%b phy=%h unc=%b ptr=%0d",
                     $time, got.req, got.phyAddr, got.uncachable, got.activeListPtr);
            $display("  expected req=%b phy=%h unc=%b ptr=%0d",
                     exp.req, exp.phyAddr, exp.uncachable, exp.activeListPtr);
            failRun();
        end
    endtask

    task automatic checkFlushReq(input logic got, input logic exp);
        if (got !== exp) begin
            $display("[ERROR] %0t: cacheFlushReq is %b, expected %b", $time, got, exp);
            failRun();
        end
    endtask

    // Stimulus and model
    initial begin
        void'($urandom(32'h304aa377));
        for (int i = 0; i < MemPipeTypes::MEM_ISSUE_WIDTH; i++) begin
            prevStage[i] = '0;
            bypassA[i] = '0;
            bypassB[i] = '0;
            heldRecord[i] = '0;
        end
        for (int i = 0; i < MemPipeTypes::CSR_SCRATCH_COUNT; i++) begin
            csrMirror[i] = '0;
        end
        stall = 1'b0;
        clear = 1'b0;
        recovery = '0;
        cacheFlushComplete = 1'b0;
        checkCount = 0;
        wait (reset === 1'b1);
        wait (reset === 1'b0);
        repeat (NUM_CYCLES) begin
            @(posedge clk);
            commitCsrWrite();
            if (!stall) begin
                heldRecord = prevStage;
            end
            #(DRIVE_DELAY);
            driveInputs();
            expectQueue.push_back(referenceModel());
        end
        repeat (2) @(posedge clk);
        if (checkCount == NUM_CYCLES && expectQueue.size() == 0) begin
            $display("Test OK");
            $finish;
        end else begin
            $display("Only %0d of %0d cycles were checked", checkCount, NUM_CYCLES);
            $display("Test FAILED");
            $fatal(1, "Not every cycle was checked");
        end
    end

    // Compare just before the next rising edge
    initial begin
        Expectation exp;
        forever begin
            @(posedge clk);
            #(SAMPLE_DELAY);
            if (expectQueue.size() > 0) begin
                exp = expectQueue.pop_front();
                checkTagAccess(MemPipeTypes::LOAD_LANE, nextStage[MemPipeTypes::LOAD_LANE],
                               exp.loadLane);
                checkTagAccess(MemPipeTypes::STORE_LANE, nextStage[MemPipeTypes::STORE_LANE],
                               exp.storeLane);
                checkDcRead(dcRead, exp.dcRead);
                checkFlushReq(cacheFlushReq, exp.cacheFlushReq);
                checkCount++;
            end
        end
    end

    initial begin
        #(TIMEOUT);
        $display("Timeout: the run did not finish within %0t", TIMEOUT);
        $display("Test FAILED");
        $fatal(1, "Watchdog expired");
    end

endmodule

`default_nettype wire

// File: verification/ClockGenerator.sv
/*
  Free-running testbench clock and a reset pulse.
  Reset drops 1 ns after its last rising edge, in step with stimulus.
*/
`timescale 1ns/1ps
`default_nettype none

module ClockGenerator #(
    parameter realtime PERIOD = 4.0,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2);
            clk = ~clk;
        end
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
    end

endmodule

`default_nettype wire

// File: source/MemoryExecutionTop.sv
/*
  Memory execution stage joined with its CSR unit.
  Bypass values, recovery and back-end control come straight from ports.
*/
`timescale 1ns/1ps
`default_nettype none

module MemoryExecutionTop (
    input  logic clk,
    input  logic reset,
    input  MemPipeTypes::MemExecRecord prevStage [MemPipeTypes::MEM_ISSUE_WIDTH],
    input  MemPipeTypes::OperandData bypassA [MemPipeTypes::MEM_ISSUE_WIDTH],
    input  MemPipeTypes::OperandData bypassB [MemPipeTypes::MEM_ISSUE_WIDTH],
    input  logic stall,
    input  logic clear,
    input  MemPipeTypes::RecoveryInfo recovery,
    input  logic cacheFlushComplete,
    output MemPipeTypes::TagAccessRecord nextStage [MemPipeTypes::MEM_ISSUE_WIDTH],
    output MemPipeTypes::DcReadRequest dcRead,
    output logic cacheFlushReq
);

    logic csrWe;
    logic [MemPipeTypes::CSR_NUMBER_WIDTH-1:0] csrNumber;
    MemPipeTypes::CsrCode csrCode;
    MemPipeTypes::DataPath csrWriteIn;
    MemPipeTypes::DataPath csrReadOut;

    MemoryExecutionStage stage (
        .clk(clk),
        .reset(reset),
        .prevStage(prevStage),
        .bypassA(bypassA),
        .bypassB(bypassB),
        .stall(stall),
        .clear(clear),
        .recovery(recovery),
        .cacheFlushComplete(cacheFlushComplete),
        .csrReadOut(csrReadOut),
        .nextStage(nextStage),
        .dcRead(dcRead),
        .cacheFlushReq(cacheFlushReq),
        .csrWe(csrWe),
        .csrNumber(csrNumber),
        .csrCode(csrCode),
        .csrWriteIn(csrWriteIn)
    );

    CsrUnit csrUnit (
        .clk(clk),
        .reset(reset),
        .csrWe(csrWe),
        .csrNumber(csrNumber),
        .csrCode(csrCode),
        .csrWriteIn(csrWriteIn),
        .csrReadOut(csrReadOut)
    );

endmodule

`default_nettype wire

// File: source/MemoryExecutionStage.sv
/*
  Memory execution stage with one register per lane.
  Outputs are combinational from the register and this cycle's side inputs.
  CSR ops and FENCE.I must arrive on lane 0; the CSR write fires every
  cycle a CSR op sits valid in lane 0, stall or not.
*/
`timescale 1ns/1ps
`default_nettype none

module MemoryExecutionStage (
    input  logic clk,
    input  logic reset,
    input  MemPipeTypes::MemExecRecord prevStage [MemPipeTypes::MEM_ISSUE_WIDTH],
    input  MemPipeTypes::OperandData bypassA [MemPipeTypes::MEM_ISSUE_WIDTH],
    input  MemPipeTypes::OperandData bypassB [MemPipeTypes::MEM_ISSUE_WIDTH],
    input  logic stall,
    input  logic clear,
    input  MemPipeTypes::RecoveryInfo recovery,
    input  logic cacheFlushComplete,
    input  MemPipeTypes::DataPath csrReadOut,
    output MemPipeTypes::TagAccessRecord nextStage [MemPipeTypes::MEM_ISSUE_WIDTH],
    output MemPipeTypes::DcReadRequest dcRead,
    output logic cacheFlushReq,
    output logic csrWe,
    output logic [MemPipeTypes::CSR_NUMBER_WIDTH-1:0] csrNumber,
    output MemPipeTypes::CsrCode csrCode,
    output MemPipeTypes::DataPath csrWriteIn
);

    MemPipeTypes::MemExecRecord pipeReg [MemPipeTypes::MEM_ISSUE_WIDTH];
    MemPipeTypes::MemOpInfo opInfo [MemPipeTypes::MEM_ISSUE_WIDTH];
    MemPipeTypes::OperandData fuOpA [MemPipeTypes::MEM_ISSUE_WIDTH];
    MemPipeTypes::OperandData fuOpB [MemPipeTypes::MEM_ISSUE_WIDTH];
    logic regValid [MemPipeTypes::MEM_ISSUE_WIDTH];
    logic flush [MemPipeTypes::MEM_ISSUE_WIDTH];
    MemPipeTypes::DataPath addrOut [MemPipeTypes::MEM_ISSUE_WIDTH];
    MemMapTypes::PhyAddr phyAddrOut [MemPipeTypes::MEM_ISSUE_WIDTH];
    MemMapTypes::MemoryMapType memMapType [MemPipeTypes::MEM_ISSUE_WIDTH];
    logic uncachable [MemPipeTypes::MEM_ISSUE_WIDTH];
    logic isCsr;
    logic isFenceI;

    // Stage register, held while stall is high
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < MemPipeTypes::MEM_ISSUE_WIDTH; i++) begin
                pipeReg[i].valid <= 1'b0;
            end
        end else if (!stall) begin
            pipeReg <= prevStage;
        end
    end

    generate
        for (genvar i = 0; i < MemPipeTypes::MEM_ISSUE_WIDTH; i++) begin : laneBlock
            SelectiveFlushDetector flushDetector (
                .toRecoveryPhase(recovery.toRecoveryPhase),
                .flushAll(recovery.flushAll),
                .headPtr(recovery.flushHeadPtr),
                .tailPtr(recovery.flushTailPtr),
                .ptr(pipeReg[i].activeListPtr),
                .hit(flush[i])
            );

            MemoryAddressUnit addressUnit (
                .base(fuOpA[i].data),
                .imm(opInfo[i].addrIn),
                .addrOut(addrOut[i]),
                .phyAddrOut(phyAddrOut[i]),
                .memMapType(memMapType[i]),
                .uncachable(uncachable[i])
            );
        end
    endgenerate

    // Operand selection and replay validity
    always_comb begin
        for (int i = 0; i < MemPipeTypes::MEM_ISSUE_WIDTH; i++) begin
            opInfo[i] = pipeReg[i].memOpInfo;
            fuOpA[i] = pipeReg[i].bypassA ? bypassA[i] : pipeReg[i].operandA;
            fuOpB[i] = pipeReg[i].bypassB ? bypassB[i] : pipeReg[i].operandB;
            // An unfinished register source forces a replay
            regValid[i] =
                (opInfo[i].operandTypeA != MemPipeTypes::OPERAND_REG || fuOpA[i].valid) &&
                (opInfo[i].operandTypeB != MemPipeTypes::OPERAND_REG || fuOpB[i].valid);
        end

        isFenceI = pipeReg[MemPipeTypes::LOAD_LANE].valid &&
                   opInfo[MemPipeTypes::LOAD_LANE].opType == MemPipeTypes::MEM_OP_FENCE &&
                   opInfo[MemPipeTypes::LOAD_LANE].isFenceI;
        // FENCE.I replays until the cache flush is done
        if (isFenceI && !cacheFlushComplete) begin
            regValid[MemPipeTypes::LOAD_LANE] = 1'b0;
        end
    end

    assign cacheFlushReq = isFenceI;

    // CSR access from lane 0
    always_comb begin
        isCsr = opInfo[MemPipeTypes::LOAD_LANE].opType == MemPipeTypes::MEM_OP_CSR;
        csrWe = pipeReg[MemPipeTypes::LOAD_LANE].valid && isCsr;
        csrNumber = opInfo[MemPipeTypes::LOAD_LANE].addrIn;
        csrCode = opInfo[MemPipeTypes::LOAD_LANE].csrCode;
        if (opInfo[MemPipeTypes::LOAD_LANE].csrIsImm) begin
            csrWriteIn = {{(MemPipeTypes::DATA_WIDTH - MemPipeTypes::CSR_IMM_WIDTH){1'b0}},
                          opInfo[MemPipeTypes::LOAD_LANE].csrImm};
        end else begin
            csrWriteIn = fuOpA[MemPipeTypes::LOAD_LANE].data;
        end
    end

    // Data cache read for the load lane
    always_comb begin
        dcRead.req = !stall && !clear &&
                     pipeReg[MemPipeTypes::LOAD_LANE].valid &&
                     regValid[MemPipeTypes::LOAD_LANE] &&
                     !flush[MemPipeTypes::LOAD_LANE] &&
                     opInfo[MemPipeTypes::LOAD_LANE].opType == MemPipeTypes::MEM_OP_LOAD;
        dcRead.phyAddr = phyAddrOut[MemPipeTypes::LOAD_LANE];
        dcRead.uncachable = uncachable[MemPipeTypes::LOAD_LANE];
        dcRead.activeListPtr = pipeReg[MemPipeTypes::LOAD_LANE].activeListPtr;
    end

    // Record for the tag access stage
    always_comb begin
        for (int i = 0; i < MemPipeTypes::MEM_ISSUE_WIDTH; i++) begin
            nextStage[i].valid = (stall || clear || reset || flush[i]) ? 1'b0 : pipeReg[i].valid;
            nextStage[i].activeListPtr = pipeReg[i].activeListPtr;
            nextStage[i].opType = opInfo[i].opType;
            nextStage[i].regValid = regValid[i];
            // CSR result replaces store data on lane 0
            if (i == MemPipeTypes::LOAD_LANE && isCsr) begin
                nextStage[i].dataIn = csrReadOut;
            end else begin
                nextStage[i].dataIn = fuOpB[i].data;
            end
            nextStage[i].addrOut = addrOut[i];
            nextStage[i].phyAddrOut = phyAddrOut[i];
            nextStage[i].memMapType = memMapType[i];
        end
    end

    // Issue logic must keep serialized ops off the store lane
    storeLaneOpCheck: assert property (
        @(posedge clk) disable iff (reset)
        !(pipeReg[MemPipeTypes::STORE_LANE].valid &&
          (opInfo[MemPipeTypes::STORE_LANE].opType inside
              {MemPipeTypes::MEM_OP_CSR, MemPipeTypes::MEM_OP_FENCE})))
        else $error("CSR or fence op held in the store lane");

endmodule

`default_nettype wire

// File: source/CsrUnit.sv
/*
  Scratch CSR file with read-modify-write.
  Four 32-bit registers at 0x340 to 0x343; other numbers read zero and
  drop writes. The read is combinational and shows the old value in the
  cycle of a write.
*/
`timescale 1ns/1ps
`default_nettype none

module CsrUnit (
    input  logic clk,
    input  logic reset,
    input  logic csrWe,
    input  logic [MemPipeTypes::CSR_NUMBER_WIDTH-1:0] csrNumber,
    input  MemPipeTypes::CsrCode csrCode,
    input  MemPipeTypes::DataPath csrWriteIn,
    output MemPipeTypes::DataPath csrReadOut
);

    MemPipeTypes::DataPath csrFile [MemPipeTypes::CSR_SCRATCH_COUNT];
    logic [MemPipeTypes::CSR_INDEX_WIDTH-1:0] csrIndex;
    logic csrMapped;
    MemPipeTypes::DataPath nextValue;

    // Low bits pick the register, upper bits must match the block base
    assign csrIndex = csrNumber[MemPipeTypes::CSR_INDEX_WIDTH-1:0];
    assign csrMapped = (csrNumber >> MemPipeTypes::CSR_INDEX_WIDTH) ==
                       (MemPipeTypes::CSR_SCRATCH_BASE >> MemPipeTypes::CSR_INDEX_WIDTH);

    always_comb begin
        if (csrMapped) begin
            csrReadOut = csrFile[csrIndex];
        end else begin
            csrReadOut = '0;
        end
    end

    always_comb begin
        case (csrCode)
            MemPipeTypes::CSR_WRITE: begin
                nextValue = csrWriteIn;
            end
            MemPipeTypes::CSR_SET: begin
                nextValue = csrReadOut | csrWriteIn;
            end
            MemPipeTypes::CSR_CLEAR: begin
                nextValue = csrReadOut & ~csrWriteIn;
            end
            default: begin
                // Unused encoding keeps the value
                nextValue = csrReadOut;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < MemPipeTypes::CSR_SCRATCH_COUNT; i++) begin
                csrFile[i] <= '0;
            end
        end else if (csrWe && csrMapped) begin
            csrFile[csrIndex] <= nextValue;
        end
    end

endmodule

`default_nettype wire

// File: source/MemoryAddressUnit.sv
/*
  Effective address, physical address and region of one lane.
  The immediate is sign-extended to the data width before the add.
  Only the top nibble is decoded; nothing checks access size or alignment.
*/
`timescale 1ns/1ps
`default_nettype none

module MemoryAddressUnit (
    input  MemPipeTypes::DataPath base,
    input  logic [MemPipeTypes::ADDR_IMM_WIDTH-1:0] imm,
    output MemPipeTypes::DataPath addrOut,
    output MemMapTypes::PhyAddr phyAddrOut,
    output MemMapTypes::MemoryMapType memMapType,
    output logic uncachable
);

    logic [MemMapTypes::REGION_TAG_WIDTH-1:0] regionTag;
    logic isIo;

    assign addrOut = base + {{MemPipeTypes::ADDR_SIGN_EXT_WIDTH{imm[MemPipeTypes::ADDR_IMM_WIDTH-1]}},
                             imm};
    assign regionTag = addrOut[MemPipeTypes::DATA_WIDTH-1 -: MemMapTypes::REGION_TAG_WIDTH];

    always_comb begin
        if (regionTag == MemMapTypes::MEMORY_REGION_TAG) begin
            memMapType = MemMapTypes::MMT_MEMORY;
        end else if (regionTag == MemMapTypes::IO_REGION_TAG) begin
            memMapType = MemMapTypes::MMT_IO;
        end else begin
            memMapType = MemMapTypes::MMT_ILLEGAL;
        end
    end

    // I/O flag on top of the region offset
    assign isIo = (memMapType == MemMapTypes::MMT_IO);
    assign phyAddrOut = {isIo, addrOut[MemMapTypes::PHY_OFFSET_WIDTH-1:0]};
    assign uncachable = phyAddrOut[MemMapTypes::PHY_ADDR_WIDTH-1];

endmodule

`default_nettype wire

// File: source/SelectiveFlushDetector.sv
/*
  Flush range check on the active-list ring.
  The range runs from headPtr inclusive to tailPtr exclusive and may wrap.
  Equal pointers mean an empty range unless flushAll is set.
*/
`timescale 1ns/1ps
`default_nettype none

module SelectiveFlushDetector (
    input  logic toRecoveryPhase,
    input  logic flushAll,
    input  MemPipeTypes::ActiveListPtr headPtr,
    input  MemPipeTypes::ActiveListPtr tailPtr,
    input  MemPipeTypes::ActiveListPtr ptr,
    output logic hit
);

    logic inRange;

    always_comb begin
        if (headPtr < tailPtr) begin
            // Plain range
            inRange = (ptr >= headPtr) && (ptr < tailPtr);
        end else if (headPtr > tailPtr) begin
            // Range wraps past the end of the ring
            inRange = (ptr >= headPtr) || (ptr < tailPtr);
        end else begin
            inRange = 1'b0;
        end
    end

    assign hit = toRecoveryPhase && (flushAll || inRange);

endmodule

`default_nettype wire

// File: source/MemPipeTypes.sv
/*
  Types of the memory pipeline around the execution stage.
  Lane 0 carries loads, CSR ops and fences; lane 1 carries stores only.
  Scratch CSRs sit at 0x340 to 0x343; other numbers are unmapped.
*/
`default_nettype none

package MemPipeTypes;

    localparam int MEM_ISSUE_WIDTH = 2;
    localparam int LOAD_LANE = 0;
    localparam int STORE_LANE = 1;

    localparam int ACTIVE_LIST_PTR_WIDTH = 5;
    localparam int DATA_WIDTH = 32;
    localparam int ADDR_IMM_WIDTH = 12;
    localparam int ADDR_SIGN_EXT_WIDTH = DATA_WIDTH - ADDR_IMM_WIDTH;

    // CSR numbering and the scratch block
    localparam int CSR_NUMBER_WIDTH = 12;
    localparam int CSR_IMM_WIDTH = 5;
    localparam int CSR_SCRATCH_COUNT = 4;
    localparam int CSR_INDEX_WIDTH = $clog2(CSR_SCRATCH_COUNT);
    localparam logic [CSR_NUMBER_WIDTH-1:0] CSR_SCRATCH_BASE = 12'h340;

    typedef logic [DATA_WIDTH-1:0] DataPath;
    typedef logic [ACTIVE_LIST_PTR_WIDTH-1:0] ActiveListPtr;

    typedef enum logic [1:0] {
        MEM_OP_LOAD,
        MEM_OP_STORE,
        MEM_OP_CSR,
        MEM_OP_FENCE
    } MemOpType;

    typedef enum logic [1:0] {
        CSR_WRITE,
        CSR_SET,
        CSR_CLEAR
    } CsrCode;

    typedef enum logic {
        OPERAND_REG,
        OPERAND_IMM
    } OperandType;

    // Valid stays low until the producer has finished
    typedef struct packed {
        logic valid;
        DataPath data;
    } OperandData;

    // addrIn doubles as the CSR number for CSR ops
    typedef struct packed {
        MemOpType opType;
        OperandType operandTypeA;
        OperandType operandTypeB;
        logic [ADDR_IMM_WIDTH-1:0] addrIn;
        logic isFenceI;
        CsrCode csrCode;
        logic csrIsImm;
        logic [CSR_IMM_WIDTH-1:0] csrImm;
    } MemOpInfo;

    typedef struct packed {
        logic valid;
        ActiveListPtr activeListPtr;
        MemOpInfo memOpInfo;
        logic bypassA;
        logic bypassB;
        OperandData operandA;
        OperandData operandB;
    } MemExecRecord;

    typedef struct packed {
        logic valid;
        ActiveListPtr activeListPtr;
        MemOpType opType;
        logic regValid;
        DataPath dataIn;
        DataPath addrOut;
        MemMapTypes::PhyAddr phyAddrOut;
        MemMapTypes::MemoryMapType memMapType;
    } TagAccessRecord;

    typedef struct packed {
        logic toRecoveryPhase;
        logic flushAll;
        ActiveListPtr flushHeadPtr;
        ActiveListPtr flushTailPtr;
    } RecoveryInfo;

    typedef struct packed {
        logic req;
        MemMapTypes::PhyAddr phyAddr;
        logic uncachable;
        ActiveListPtr activeListPtr;
    } DcReadRequest;

endpackage

`default_nettype wire

// File: source/MemMapTypes.sv
/*
  Memory map of the execution stage.
  The top nibble of a logical address picks the region; only the
  memory and I/O nibbles are legal. The physical address keeps the low
  28 bits and puts the I/O flag above them.
*/
`default_nettype none

package MemMapTypes;

    // Physical address is the I/O flag plus the region offset
    localparam int PHY_ADDR_WIDTH = 29;
    localparam int PHY_OFFSET_WIDTH = PHY_ADDR_WIDTH - 1;

    // Top nibble of the logical address selects the region
    localparam int REGION_TAG_WIDTH = 4;
    localparam logic [REGION_TAG_WIDTH-1:0] MEMORY_REGION_TAG = 4'h8;
    localparam logic [REGION_TAG_WIDTH-1:0] IO_REGION_TAG = 4'h4;

    typedef enum logic [1:0] {
        MMT_MEMORY,
        MMT_IO,
        MMT_ILLEGAL
    } MemoryMapType;

    // Bit PHY_ADDR_WIDTH-1 set means uncachable I/O space
    typedef logic [PHY_ADDR_WIDTH-1:0] PhyAddr;

endpackage

`default_nettype wire
